/* common/sddr_pkg.sv */
package sddr_pkg;

    // Address field widths
    localparam int BANK_BITS = 3;
    localparam int ROW_BITS  = 14;
    localparam int COL_BITS  = 10;

    // Data path
    localparam int DATA_BITS = 16;
    localparam int BURST_LEN = 8;

    localparam int BYTE_BITS  = $clog2(DATA_BITS / 8);  // Byte offset inside a word
    localparam int HALF_BURST = BURST_LEN / 2;          // Lane pairs per burst

    typedef logic [BANK_BITS-1:0] bank_t;
    typedef logic [ROW_BITS-1:0]  row_t;
    typedef logic [COL_BITS-1:0]  col_t;

    // Byte address as bank, row, col, byte offset from the top down
    typedef logic [BANK_BITS+ROW_BITS+COL_BITS+BYTE_BITS-1:0] host_addr_t;

    typedef logic [ROW_BITS-1:0] pin_addr_t;   // A[13:0]

    typedef logic [DATA_BITS-1:0] word_t;

    // Word 0 sits in the low bits
    typedef logic [BURST_LEN*DATA_BITS-1:0] burst_t;

    typedef logic [16:0] timer_t;

    // CS, RAS, CAS, WE
    typedef enum logic [3:0] {
        NOP      = 4'b0111,
        ACTIVATE = 4'b0011,
        READ     = 4'b0101,
        WRITE    = 4'b0100,
        REFRESH  = 4'b0001
    } dram_cmd_e;

    typedef struct packed {
        host_addr_t addr;
        logic       write;
        burst_t     data;   // Ignored on reads
    } host_req_t;

    // Everything on the DRAM command side of the PHY
    typedef struct packed {
        logic      cke;
        dram_cmd_e cmd;
        bank_t     bank;
        pin_addr_t addr;
        logic      odt;
    } dram_bus_t;

    typedef struct packed {
        word_t lane0;   // Even words
        word_t lane1;   // Odd words
    } lane_pair_t;

endpackage

/* list.f */
common/sddr_pkg.sv
logic/request_latch.sv
logic/refresh_timer.sv
sequencer/bank_sequencer.sv
logic/write_serializer.sv
logic/read_capture.sv
logic/sddr_ctrl.sv
testbench/tb_clock.sv
testbench/sddr_ctrl_tb.sv

/* logic/read_capture.sv */
`timescale 1ns/1ps

module read_capture (
    input  logic             ddr_clock_i,
    input  logic             arst_n_i,
    input  logic             rd_done_i,
    input  sddr_pkg::burst_t read_burst_i,
    output logic             data_rsp_ready_o,
    output sddr_pkg::burst_t data_rsp_data_o
);

    // Response lags rd_done by one clock
    always_ff @(posedge ddr_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_rsp_ready_o <= 1'b0;
        end else begin
            data_rsp_ready_o <= rd_done_i;
        end
    end

    // Last burst stays until the next read
    always_ff @(posedge ddr_clock_i) begin
        if (rd_done_i) begin
            data_rsp_data_o <= read_burst_i;
        end
    end

endmodule

/* logic/refresh_timer.sv */
`timescale 1ns/1ps

module refresh_timer #(
    parameter int T_REFI = 3120
) (
    input  logic ddr_clock_i,
    input  logic arst_n_i,
    input  logic refresh_issued_i,
    output logic refresh_due_o
);
    import sddr_pkg::*;

    timer_t interval_cnt;

    always_ff @(posedge ddr_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            interval_cnt  <= timer_t'(T_REFI);
            refresh_due_o <= 1'b0;
        end else if (refresh_issued_i) begin
            interval_cnt  <= timer_t'(T_REFI);   // Next interval counts from the REFRESH
            refresh_due_o <= 1'b0;
        end else if (interval_cnt != '0) begin
            interval_cnt  <= interval_cnt - 1'b1;
            refresh_due_o <= (interval_cnt == timer_t'(1));
        end
    end

    // A REFRESH is only sent in answer to a due flag
    assert property (@(posedge ddr_clock_i) disable iff (!arst_n_i)
        refresh_issued_i |-> refresh_due_o);

endmodule

/* logic/request_latch.sv */
`timescale 1ns/1ps

module request_latch (
    input  logic                ddr_clock_i,
    input  logic                arst_n_i,

    input  logic                data_cmd_valid_i,
    input  sddr_pkg::host_req_t data_cmd_i,
    output logic                data_cmd_ack_o,

    input  logic                req_release_i,
    output logic                req_pending_o,
    output sddr_pkg::host_req_t req_o
);

    logic accept;

    assign data_cmd_ack_o = !req_pending_o;   // Ready only while empty
    assign accept         = data_cmd_valid_i && data_cmd_ack_o;

    always_ff @(posedge ddr_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_pending_o <= 1'b0;
        end else if (accept) begin
            req_pending_o <= 1'b1;
        end else if (req_release_i) begin
            req_pending_o <= 1'b0;
        end
    end

    // Held stable until the sequencer lets go
    always_ff @(posedge ddr_clock_i) begin
        if (accept) begin
            req_o <= data_cmd_i;
        end
    end

    // Sequencer must only release what it was given
    assert property (@(posedge ddr_clock_i) disable iff (!arst_n_i)
        req_release_i |-> req_pending_o);

endmodule

/* logic/sddr_ctrl.sv */
`timescale 1ns/1ps

module sddr_ctrl #(
    parameter int T_RCD  = 6,
    parameter int T_RP   = 6,
    parameter int T_WR   = 6,
    parameter int T_RFC  = 64,
    parameter int T_REFI = 3120,
    parameter int T_CL   = 6,
    parameter int T_CWL  = 5
) (
    input  logic                 ddr_clock_i,
    input  logic                 arst_n_i,

    // Host side
    input  logic                 data_cmd_valid_i,
    input  sddr_pkg::host_req_t  data_cmd_i,
    output logic                 data_cmd_ack_o,
    output logic                 data_rsp_ready_o,
    output sddr_pkg::burst_t     data_rsp_data_o,

    // PHY side
    output sddr_pkg::dram_bus_t  dram_o,
    output sddr_pkg::lane_pair_t dq_pair_o,
    input  sddr_pkg::burst_t     read_burst_i,
    output logic                 data_write_o,
    output logic                 data_transfer_o
);
    import sddr_pkg::*;

    host_req_t req;
    logic      req_pending;
    logic      req_release;
    logic      refresh_due;
    logic      refresh_issued;
    logic      wr_start;
    logic      rd_done;

    request_latch u_request_latch (
        .ddr_clock_i      (ddr_clock_i),
        .arst_n_i         (arst_n_i),
        .data_cmd_valid_i (data_cmd_valid_i),
        .data_cmd_i       (data_cmd_i),
        .data_cmd_ack_o   (data_cmd_ack_o),
        .req_release_i    (req_release),
        .req_pending_o    (req_pending),
        .req_o            (req)
    );

    refresh_timer #(.T_REFI(T_REFI)) u_refresh_timer (
        .ddr_clock_i      (ddr_clock_i),
        .arst_n_i         (arst_n_i),
        .refresh_issued_i (refresh_issued),
        .refresh_due_o    (refresh_due)
    );

    bank_sequencer #(
        .T_RCD (T_RCD),
        .T_RP  (T_RP),
        .T_WR  (T_WR),
        .T_RFC (T_RFC),
        .T_CL  (T_CL),
        .T_CWL (T_CWL)
    ) u_bank_sequencer (
        .ddr_clock_i      (ddr_clock_i),
        .arst_n_i         (arst_n_i),
        .req_pending_i    (req_pending),
        .req_i            (req),
        .refresh_due_i    (refresh_due),
        .refresh_issued_o (refresh_issued),
        .req_release_o    (req_release),
        .wr_start_o       (wr_start),
        .rd_done_o        (rd_done),
        .dram_o           (dram_o),
        .data_write_o     (data_write_o),
        .data_transfer_o  (data_transfer_o)
    );

    write_serializer u_write_serializer (
        .ddr_clock_i (ddr_clock_i),
        .arst_n_i    (arst_n_i),
        .wr_start_i  (wr_start),
        .burst_i     (req.data),   // Still held by the latch
        .dq_pair_o   (dq_pair_o)
    );

    read_capture u_read_capture (
        .ddr_clock_i      (ddr_clock_i),
        .arst_n_i         (arst_n_i),
        .rd_done_i        (rd_done),
        .read_burst_i     (read_burst_i),
        .data_rsp_ready_o (data_rsp_ready_o),
        .data_rsp_data_o  (data_rsp_data_o)
    );

endmodule

/* logic/write_serializer.sv */
`timescale 1ns/1ps

module write_serializer (
    input  logic                 ddr_clock_i,
    input  logic                 arst_n_i,
    input  logic                 wr_start_i,
    input  sddr_pkg::burst_t     burst_i,
    output sddr_pkg::lane_pair_t dq_pair_o
);
    import sddr_pkg::*;

    localparam int CNT_BITS = $clog2(HALF_BURST + 1);

    typedef logic [CNT_BITS-1:0] pair_cnt_t;

    word_t     even_q [HALF_BURST];
    word_t     odd_q  [HALF_BURST];
    pair_cnt_t pairs_left;

    always_ff @(posedge ddr_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pairs_left <= '0;
        end else if (wr_start_i) begin
            pairs_left <= pair_cnt_t'(HALF_BURST);
        end else if (pairs_left != '0) begin
            pairs_left <= pairs_left - 1'b1;
        end
    end

    // Even words feed lane 0, odd words lane 1
    always_ff @(posedge ddr_clock_i) begin
        if (wr_start_i) begin
            for (int i = 0; i < HALF_BURST; i++) begin
                even_q[i] <= burst_i[(2*i)*DATA_BITS +: DATA_BITS];
                odd_q[i]  <= burst_i[(2*i+1)*DATA_BITS +: DATA_BITS];
            end
        end else if (pairs_left != '0) begin
            for (int i = 0; i < HALF_BURST - 1; i++) begin
                even_q[i] <= even_q[i+1];
                odd_q[i]  <= odd_q[i+1];
            end
        end
    end

    assign dq_pair_o = '{lane0: even_q[0], lane1: odd_q[0]};

    // Writes are spaced well past the end of the previous burst
    assert property (@(posedge ddr_clock_i) disable iff (!arst_n_i)
        wr_start_i |-> pairs_left == '0);

endmodule

/* sequencer/bank_sequencer.sv */
`timescale 1ns/1ps

module bank_sequencer #(
    parameter int T_RCD = 6,
    parameter int T_RP  = 6,
    parameter int T_WR  = 6,
    parameter int T_RFC = 64,
    parameter int T_CL  = 6,
    parameter int T_CWL = 5
) (
    input  logic                ddr_clock_i,
    input  logic                arst_n_i,

    input  logic                req_pending_i,
    input  sddr_pkg::host_req_t req_i,
    input  logic                refresh_due_i,
    output logic                refresh_issued_o,

    output logic                req_release_o,
    output logic                wr_start_o,
    output logic                rd_done_o,

    output sddr_pkg::dram_bus_t dram_o,
    output logic                data_write_o,
    output logic                data_transfer_o
);
    import sddr_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        ACTIVATE_ROW,
        ISSUE_OP,
        WRITE_WAIT,
        WRITE_BURST,
        READ_WAIT,
        RECOVER
    } state_e;

    state_e state;
    timer_t delay_cnt;
    logic   delay_zero;

    bank_t  req_bank;
    row_t   req_row;
    col_t   req_col;

    assign req_bank = req_i.addr[$bits(host_addr_t)-1 -: BANK_BITS];
    assign req_row  = req_i.addr[BYTE_BITS+COL_BITS +: ROW_BITS];
    assign req_col  = req_i.addr[BYTE_BITS +: COL_BITS];

    // A load of N lets the next step fire N+1 clocks later
    assign delay_zero = (delay_cnt == '0);

    always_ff @(posedge ddr_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state            <= IDLE;
            delay_cnt        <= '0;
            dram_o           <= '{cke: 1'b0, cmd: NOP, bank: '0, addr: '0, odt: 1'b0};
            refresh_issued_o <= 1'b0;
            req_release_o    <= 1'b0;
            wr_start_o       <= 1'b0;
            rd_done_o        <= 1'b0;
            data_write_o     <= 1'b0;
            data_transfer_o  <= 1'b0;
        end else begin
            dram_o.cke       <= 1'b1;
            dram_o.cmd       <= NOP;
            dram_o.bank      <= '0;
            dram_o.addr      <= '0;
            refresh_issued_o <= 1'b0;
            req_release_o    <= 1'b0;
            wr_start_o       <= 1'b0;
            rd_done_o        <= 1'b0;

            if (!delay_zero) begin
                delay_cnt <= delay_cnt - 1'b1;
            end

            // Pulses that lead the next step by one cycle
            if (delay_cnt == timer_t'(1)) begin
                if (state == WRITE_WAIT) wr_start_o <= 1'b1;     // Serializer loads here
                if (state == WRITE_BURST) req_release_o <= 1'b1; // Last data cycle
            end

            if (delay_zero) begin
                case (state)
                    IDLE: begin
                        if (refresh_due_i) begin
                            dram_o.cmd       <= REFRESH;
                            refresh_issued_o <= 1'b1;
                            delay_cnt        <= timer_t'(T_RFC - 1);
                        end else if (req_pending_i) begin
                            state <= ACTIVATE_ROW;
                        end
                    end
                    ACTIVATE_ROW: begin
                        dram_o.cmd  <= ACTIVATE;
                        dram_o.bank <= req_bank;
                        dram_o.addr <= pin_addr_t'(req_row);
                        state       <= ISSUE_OP;
                        delay_cnt   <= timer_t'(T_RCD - 1);
                    end
                    ISSUE_OP: begin
                        dram_o.bank     <= req_bank;
                        dram_o.addr     <= pin_addr_t'({1'b1, req_col}); // A10 auto-precharge
                        data_transfer_o <= 1'b1;
                        if (req_i.write) begin
                            dram_o.cmd <= WRITE;
                            dram_o.odt <= 1'b1;
                            state      <= WRITE_WAIT;
                            delay_cnt  <= timer_t'(T_CWL - 1);
                        end else begin
                            dram_o.cmd <= READ;
                            state      <= READ_WAIT;
                            delay_cnt  <= timer_t'(T_CL + HALF_BURST - 1);
                        end
                    end
                    WRITE_WAIT: begin
                        data_write_o <= 1'b1;
                        state        <= WRITE_BURST;
                        delay_cnt    <= timer_t'(HALF_BURST - 1);
                    end
                    WRITE_BURST: begin
                        data_write_o    <= 1'b0;
                        data_transfer_o <= 1'b0;
                        dram_o.odt      <= 1'b0;
                        state           <= RECOVER;
                        delay_cnt       <= timer_t'(T_WR + T_RP - 2);
                    end
                    READ_WAIT: begin
                        rd_done_o       <= 1'b1;
                        req_release_o   <= 1'b1;
                        data_transfer_o <= 1'b0;
                        state           <= RECOVER;
                        delay_cnt       <= timer_t'(T_RP - 1);
                    end
                    RECOVER: state <= IDLE;   // Auto-precharge done
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // READ or WRITE lands T_RCD after the ACTIVATE of its bank
    assert property (@(posedge ddr_clock_i) disable iff (!arst_n_i)
        dram_o.cmd inside {READ, WRITE} |->
            $past(dram_o.cmd, T_RCD) == ACTIVATE &&
            $past(dram_o.bank, T_RCD) == dram_o.bank);

    // Column fits below A10 and is still the one held at ACTIVATE
    assert property (@(posedge ddr_clock_i) disable iff (!arst_n_i)
        dram_o.cmd inside {READ, WRITE} |->
            dram_o.addr[10] && dram_o.addr[ROW_BITS-1:11] == '0 &&
            dram_o.addr[COL_BITS-1:0] == $past(req_col, T_RCD + 1));

endmodule

/* testbench/sddr_ctrl_tb.sv */
`timescale 1ns/1ps

module sddr_ctrl_tb;
    import sddr_pkg::*;

    localparam int CLK_NS = 4;
    localparam int T_RCD  = 3;
    localparam int T_CL   = 5;
    localparam int T_CWL  = 5;
    localparam int T_WR   = 5;
    localparam int T_RP   = 3;
    localparam int T_RFC  = 8;
    localparam int T_REFI = 200;
    localparam int N_REQ  = 42;   // Directed write and read plus forty random

    typedef struct packed {
        bank_t                bank;
        row_t                 row;
        col_t                 col;
        logic [BYTE_BITS-1:0] byte_off;
    } addr_fields_t;

    typedef struct packed {
        dram_cmd_e cmd;
        bank_t     bank;
        pin_addr_t addr;
        int        cycle;
    } cmd_rec_t;

    logic         clk;
    logic         arst_n;
    logic         valid;
    host_req_t    req;
    logic         ack;
    logic         rsp_ready;
    burst_t       rsp_data;
    dram_bus_t    dram;
    lane_pair_t   dq_pair;
    burst_t       read_burst = '0;
    logic         data_write;
    logic         data_transfer;
    logic         xfer_smp = 1'b0;
    logic         odt_smp = 1'b0;

    integer       seed;
    int           cycle;
    int           errors;
    int           checks;
    int           accepted;
    int           acts;
    int           ops;
    int           sent;
    int           refreshes;
    int           refresh_start;
    int           lane_idx;
    int           test_start_errors;
    int           act_cycle;
    int           ref_cycle = -1;
    int           xfer_last = -1;
    int           odt_last = -1;
    host_req_t    cur;
    addr_fields_t cur_f;
    row_t         open_row;

    cmd_rec_t     cmd_q[$];
    lane_pair_t   lane_q[$];
    burst_t       rsp_q[$];
    host_req_t    acc_q[$];
    burst_t       wr_exp_q[$];
    burst_t       rd_exp_q[$];

    tb_clock #(.PERIOD_NS(CLK_NS)) u_clock (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    sddr_ctrl #(
        .T_RCD  (T_RCD),
        .T_RP   (T_RP),
        .T_WR   (T_WR),
        .T_RFC  (T_RFC),
        .T_REFI (T_REFI),
        .T_CL   (T_CL),
        .T_CWL  (T_CWL)
    ) uut (
        .ddr_clock_i      (clk),
        .arst_n_i         (arst_n),
        .data_cmd_valid_i (valid),
        .data_cmd_i       (req),
        .data_cmd_ack_o   (ack),
        .data_rsp_ready_o (rsp_ready),
        .data_rsp_data_o  (rsp_data),
        .dram_o           (dram),
        .dq_pair_o        (dq_pair),
        .read_burst_i     (read_burst),
        .data_write_o     (data_write),
        .data_transfer_o  (data_transfer)
    );

    // DRAM read data, a mix of address and word index
    function automatic burst_t model_burst(input bank_t b, input row_t r, input col_t c);
        burst_t d;
        for (int i = 0; i < BURST_LEN; i++) begin
            d[i*DATA_BITS +: DATA_BITS] = {b, r[5:0], c[6:0]} ^ word_t'(i * 16'h3c5a + r[13:6]);
        end
        return d;
    endfunction

    function automatic pin_addr_t exp_act_addr(input host_req_t q);
        addr_fields_t a;
        a = addr_fields_t'(q.addr);
        return a.row;
    endfunction

    function automatic pin_addr_t exp_op_addr(input host_req_t q);
        addr_fields_t a;
        pin_addr_t    p;
        a      = addr_fields_t'(q.addr);
        p      = '0;
        p[9:0] = a.col;
        p[10]  = 1'b1;   // Auto-precharge
        return p;
    endfunction

    function automatic dram_cmd_e exp_op_cmd(input host_req_t q);
        if (q.write) begin
            return WRITE;
        end
        return READ;
    endfunction

    function automatic lane_pair_t exp_lanes(input burst_t d, input int k);
        lane_pair_t p;
        p.lane0 = d[(2*k)*DATA_BITS +: DATA_BITS];
        p.lane1 = d[(2*k+1)*DATA_BITS +: DATA_BITS];
        return p;
    endfunction

    function automatic host_req_t random_req(input logic wr);
        host_req_t r;
        r.addr  = host_addr_t'({$random(seed), $random(seed)});
        r.write = wr;
        for (int i = 0; i < BURST_LEN; i++) begin
            r.data[i*DATA_BITS +: DATA_BITS] = word_t'($random(seed));
        end
        return r;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at cycle %0d: %s", cycle, msg);
    endtask

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        if (cond !== 1'b1) begin
            report_error(msg);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_cmd(input string what, input dram_cmd_e got, input dram_cmd_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_bank(input string what, input bank_t got, input bank_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_pin_addr(input string what, input pin_addr_t got, input pin_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_burst(input string what, input burst_t got, input burst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_lanes(input string what, input lane_pair_t got, input lane_pair_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", what, got, exp);
        end
    endtask

    task automatic send_req(input host_req_t r);
        req   = r;
        valid = 1'b1;
        @(posedge clk);
        while (!ack) @(posedge clk);   // Held until the latch takes it
        sent++;
        @(negedge clk);
        valid = 1'b0;
    endtask

    // Latch empty again, then let the compare process drain
    task automatic wait_idle();
        @(posedge clk);
        while (!ack) @(posedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        $display("test %-10s %s", name, (errors == test_start_errors) ? "ok" : "FAILED");
        test_start_errors = errors;
    endtask

    // DRAM pin monitor
    always @(posedge clk) begin
        cycle++;
        if (arst_n) begin
            if (valid && ack) begin
                accepted++;
                acc_q.push_back(req);
            end
            if (dram.cmd == ACTIVATE) acts++;
            if (dram.cmd inside {READ, WRITE}) ops++;
            if (dram.cmd != NOP) cmd_q.push_back('{dram.cmd, dram.bank, dram.addr, cycle});
            if (data_write) lane_q.push_back(dq_pair);
            if (rsp_ready) rsp_q.push_back(rsp_data);
            xfer_smp = data_transfer;
            odt_smp  = dram.odt;
        end
    end

    always @(negedge clk) begin : compare
        cmd_rec_t r;
        if (arst_n && ack && accepted > ops) begin
            report_error("ack high while a request is held");
        end
        while (cmd_q.size() > 0) begin
            r = cmd_q.pop_front();
            case (r.cmd)
                REFRESH: begin
                    if (ref_cycle >= 0 && r.cycle - ref_cycle > T_REFI + 60) begin
                        report_error("REFRESH interval too long");
                    end
                    ref_cycle = r.cycle;
                    refreshes++;
                end
                ACTIVATE: begin
                    if (ref_cycle >= 0 && r.cycle - ref_cycle <= T_RFC) begin
                        report_error("ACTIVATE inside T_RFC after REFRESH");
                    end
                    if (acc_q.size() == 0) begin
                        report_error("ACTIVATE with no accepted request");
                    end else begin
                        cur = acc_q.pop_front();
                    end
                    cur_f     = addr_fields_t'(cur.addr);
                    act_cycle = r.cycle;
                    open_row  = row_t'(r.addr);
                    check_bank("act bank", r.bank, cur_f.bank);
                    check_pin_addr("act addr", r.addr, exp_act_addr(cur));
                end
                READ, WRITE: begin
                    check_cmd("op cmd", r.cmd, exp_op_cmd(cur));
                    if (r.cycle != act_cycle + T_RCD) begin
                        report_error("READ or WRITE not T_RCD cycles after ACTIVATE");
                    end
                    check_bank("op bank", r.bank, cur_f.bank);
                    check_pin_addr("op addr", r.addr, exp_op_addr(cur));
                    if (r.cmd == READ) begin
                        read_burst = model_burst(r.bank, open_row, col_t'(r.addr));
                        rd_exp_q.push_back(model_burst(cur_f.bank, cur_f.row, cur_f.col));
                        xfer_last = r.cycle + T_CL + HALF_BURST - 1;
                    end else begin
                        wr_exp_q.push_back(cur.data);
                        xfer_last = r.cycle + T_CWL + HALF_BURST - 1;
                        odt_last  = xfer_last;   // odt spans the same write window
                    end
                end
                default: report_error("unexpected DRAM command");
            endcase
        end
        if (arst_n) begin
            check_flag("data_transfer_o", xfer_smp, cycle <= xfer_last);
            check_flag("dram odt", odt_smp, cycle <= odt_last);
        end
        while (lane_q.size() > 0) begin
            if (wr_exp_q.size() == 0) begin
                report_error("write data with no WRITE in flight");
                lane_q.delete();
            end else begin
                check_lanes("dq pair", lane_q.pop_front(), exp_lanes(wr_exp_q[0], lane_idx));
                lane_idx++;
                if (lane_idx == HALF_BURST) begin
                    lane_idx = 0;
                    void'(wr_exp_q.pop_front());
                end
            end
        end
        while (rsp_q.size() > 0) begin
            if (rd_exp_q.size() == 0) begin
                report_error("response with no READ in flight");
                rsp_q.delete();
            end else begin
                check_burst("rsp data", rsp_q.pop_front(), rd_exp_q.pop_front());
            end
        end
    end

    initial begin : watchdog
        #(N_REQ * 60 * CLK_NS + 2000);
        $display("Timeout: the run did not complete in the allowed time");
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed  = 32'hcc16_bdde;
        valid = 1'b0;
        req   = '0;

        @(negedge clk);
        check_cmd("dram cmd", dram.cmd, NOP);
        expect_true(ack && !data_write && !rsp_ready, "outputs busy during reset");
        wait (arst_n);
        @(posedge clk);
        @(negedge clk);
        check_cmd("dram cmd", dram.cmd, NOP);
        expect_true(dram.cke, "cke still low after the first clock");
        expect_true(ack && !data_write && !rsp_ready, "outputs busy after reset");
        end_test("reset");

        send_req(random_req(1'b1));
        wait_idle();
        end_test("write");

        send_req(random_req(1'b0));
        wait_idle();
        end_test("read");

        for (int i = 0; i < 40; i++) begin
            send_req(random_req(1'($random(seed))));
        end
        wait_idle();
        expect_true(acts == sent, "ACTIVATE count differs from requests sent");
        expect_true(ops == sent, "READ and WRITE count differs from requests sent");
        end_test("ordering");

        refresh_start = refreshes;
        repeat (2 * T_REFI + 60) @(negedge clk);   // Long idle stretch
        expect_true(refreshes - refresh_start >= 2, "too few REFRESH commands while idle");
        expect_true(acc_q.size() == 0 && wr_exp_q.size() == 0 && rd_exp_q.size() == 0,
            "requests left without a matching DRAM transfer");
        end_test("refresh");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Two rising edges in reset, release on a falling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule
